//--- all.f
hw/usb_pkg.sv
hw/telemetry_pkg.sv
hw/reset_sync.sv
hw/telemetry_capture.sv
hw/endpoint_arbiter.sv
hw/axis_skid.sv
hw/bulk_in_bridge.sv
tb/bulk_in_bridge_tb.sv

//--- hw/axis_skid.sv
`timescale 1ns/1ps

module axis_skid (
  input  logic                clock,
  input  logic                areset_n,
  input  logic                usb_reset_i,
  input  usb_pkg::axis_beat_t s_beat_i,
  input  logic                s_tvalid_i,
  input  logic                m_tready_i,
  output logic                s_tready_o,
  output usb_pkg::axis_beat_t m_beat_o,
  output logic                m_tvalid_o
);

  usb_pkg::axis_beat_t m_beat_q;
  usb_pkg::axis_beat_t skid_beat_q;
  logic                m_tvalid_q;
  logic                skid_valid_q;
  logic                out_free;

  // main register empties or drains this cycle
  assign out_free = m_tready_i || !m_tvalid_q;

  // ready comes from a register only
  assign s_tready_o = ~skid_valid_q;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      m_tvalid_q   <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (usb_reset_i) begin
      m_tvalid_q   <= 1'b0;
      skid_valid_q <= 1'b0;
    end else begin
      if (out_free) begin
        m_tvalid_q   <= skid_valid_q || s_tvalid_i;
        skid_valid_q <= 1'b0;  // skid drains into main
      end else if (s_tvalid_i && !skid_valid_q) begin
        skid_valid_q <= 1'b1;  // output stalled, park the beat
      end
    end
  end

  always_ff @(posedge clock) begin
    if (out_free) begin
      m_beat_q <= skid_valid_q ? skid_beat_q : s_beat_i;
    end
    if (!skid_valid_q) begin
      skid_beat_q <= s_beat_i;  // track input while empty
    end
  end

  assign m_beat_o   = m_beat_q;
  assign m_tvalid_o = m_tvalid_q;

endmodule

//--- hw/bulk_in_bridge.sv
`timescale 1ns/1ps

module bulk_in_bridge (
  input  logic                       clock,
  input  logic                       areset_n,
  input  logic                       usb_bus_reset_i,
  input  telemetry_pkg::usb_events_t usb_events_i,
  input  usb_pkg::endpoint_t         blk_endpt_i,
  input  logic                       blk_in_ready_i,
  input  usb_pkg::axis_beat_t        s_axis_i,
  input  logic                       s_axis_tvalid_i,
  output logic                       s_axis_tready_o,
  input  logic                       m_axis_tready_i,
  output logic                       reset_no,
  output logic                       usb_reset_o,
  output usb_pkg::axis_beat_t        m_axis_o,
  output logic                       m_axis_tvalid_o,
  output logic                       blk_in_ready_o,
  output logic                       has_telemetry_o
);

  usb_pkg::axis_beat_t   tele_beat;
  logic                  tele_tvalid;
  logic                  tele_tready;
  telemetry_pkg::level_t tele_level;

  usb_pkg::axis_beat_t   mux_beat;
  logic                  mux_tvalid;
  logic                  mux_tready;

  reset_sync u_reset_sync (
    .clock           (clock),
    .areset_n        (areset_n),
    .usb_bus_reset_i (usb_bus_reset_i),
    .reset_no        (reset_no),
    .usb_reset_o     (usb_reset_o)
  );

  // kept out of the core reset so bus resets get logged
  telemetry_capture u_telemetry_capture (
    .clock        (clock),
    .reset_n_i    (reset_no),
    .usb_events_i (usb_events_i),
    .tready_i     (tele_tready),
    .beat_o       (tele_beat),
    .tvalid_o     (tele_tvalid),
    .level_o      (tele_level)
  );

  endpoint_arbiter u_endpoint_arbiter (
    .clock           (clock),
    .areset_n        (areset_n),
    .usb_reset_i     (usb_reset_o),
    .blk_endpt_i     (blk_endpt_i),
    .blk_in_ready_i  (blk_in_ready_i),
    .level_i         (tele_level),
    .user_beat_i     (s_axis_i),
    .user_tvalid_i   (s_axis_tvalid_i),
    .tele_beat_i     (tele_beat),
    .tele_tvalid_i   (tele_tvalid),
    .tready_i        (mux_tready),
    .user_tready_o   (s_axis_tready_o),
    .tele_tready_o   (tele_tready),
    .beat_o          (mux_beat),
    .tvalid_o        (mux_tvalid),
    .blk_in_ready_o  (blk_in_ready_o),
    .has_telemetry_o (has_telemetry_o)
  );

  axis_skid u_axis_skid (
    .clock       (clock),
    .areset_n    (areset_n),
    .usb_reset_i (usb_reset_o),
    .s_beat_i    (mux_beat),
    .s_tvalid_i  (mux_tvalid),
    .m_tready_i  (m_axis_tready_i),
    .s_tready_o  (mux_tready),
    .m_beat_o    (m_axis_o),
    .m_tvalid_o  (m_axis_tvalid_o)
  );

endmodule

//--- hw/endpoint_arbiter.sv
`timescale 1ns/1ps

module endpoint_arbiter (
  input  logic                  clock,
  input  logic                  areset_n,
  input  logic                  usb_reset_i,
  input  usb_pkg::endpoint_t    blk_endpt_i,
  input  logic                  blk_in_ready_i,
  input  telemetry_pkg::level_t level_i,
  input  usb_pkg::axis_beat_t   user_beat_i,
  input  logic                  user_tvalid_i,
  input  usb_pkg::axis_beat_t   tele_beat_i,
  input  logic                  tele_tvalid_i,
  input  logic                  tready_i,
  output logic                  user_tready_o,
  output logic                  tele_tready_o,
  output usb_pkg::axis_beat_t   beat_o,
  output logic                  tvalid_o,
  output logic                  blk_in_ready_o,
  output logic                  has_telemetry_o
);

  logic tele_sel_q;
  logic blk_in_ready_q;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      tele_sel_q     <= 1'b0;
      blk_in_ready_q <= 1'b0;
    end else begin
      if (usb_reset_i) tele_sel_q <= 1'b0;
      else tele_sel_q <= (blk_endpt_i == usb_pkg::telemetry_ep);
      // enough queued telemetry also asks for an IN transfer
      blk_in_ready_q <= blk_in_ready_i || (level_i >= telemetry_pkg::ready_level);
    end
  end

  assign beat_o   = tele_sel_q ? tele_beat_i : user_beat_i;
  assign tvalid_o = tele_sel_q ? tele_tvalid_i : user_tvalid_i;

  assign user_tready_o = ~tele_sel_q & tready_i;  // deselected peer is stalled
  assign tele_tready_o = tele_sel_q & tready_i;

  assign blk_in_ready_o  = blk_in_ready_q;
  assign has_telemetry_o = (level_i >= telemetry_pkg::present_level);

endmodule

//--- hw/reset_sync.sv
`timescale 1ns/1ps

module reset_sync (
  input  logic clock,
  input  logic areset_n,
  input  logic usb_bus_reset_i,
  output logic reset_no,
  output logic usb_reset_o
);

  logic [1:0] sync_q;  // metastability pair
  logic       core_n_q;

  // async assert, sync release
  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      sync_q   <= 2'b00;
      core_n_q <= 1'b0;
    end else begin
      sync_q   <= {sync_q[0], 1'b1};
      core_n_q <= sync_q[1] & ~usb_bus_reset_i;  // bus reset pulls the core back
    end
  end

  assign reset_no    = sync_q[1];
  assign usb_reset_o = ~core_n_q;

endmodule

//--- hw/telemetry_capture.sv
`timescale 1ns/1ps

module telemetry_capture (
  input  logic                       clock,
  input  logic                       reset_n_i,
  input  telemetry_pkg::usb_events_t usb_events_i,
  input  logic                       tready_i,
  output usb_pkg::axis_beat_t        beat_o,
  output logic                       tvalid_o,
  output telemetry_pkg::level_t      level_o
);

  logic [telemetry_pkg::timestamp_width-1:0] timestamp_q;

  telemetry_pkg::telemetry_record_t mem [telemetry_pkg::fifo_depth];
  telemetry_pkg::telemetry_record_t rd_record;

  logic [telemetry_pkg::fifo_addr_width-1:0] wr_ptr_q;
  logic [telemetry_pkg::fifo_addr_width-1:0] rd_ptr_q;
  telemetry_pkg::level_t                     level_q;

  telemetry_pkg::readout_state_e        state_q;
  logic [usb_pkg::pkt_count_width-1:0]  byte_cnt_q;
  logic                                 last_q;  // decided at the low byte

  logic wr_en;
  logic xfer;
  logic rd_done;

  // drop new records while full
  assign wr_en = (|usb_events_i) &&
                 (level_q != telemetry_pkg::level_t'(telemetry_pkg::fifo_depth));
  assign xfer    = tvalid_o && tready_i;
  assign rd_done = xfer && (state_q == telemetry_pkg::read_high);

  assign rd_record = mem[rd_ptr_q];

  // free-running, wraps at 11 bits
  always_ff @(posedge clock or negedge reset_n_i) begin
    if (!reset_n_i) begin
      timestamp_q <= '0;
    end else begin
      timestamp_q <= timestamp_q + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= '{events: usb_events_i, timestamp: timestamp_q};
    end
  end

  always_ff @(posedge clock or negedge reset_n_i) begin
    if (!reset_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (wr_en) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rd_done) rd_ptr_q <= rd_ptr_q + 1'b1;  // record leaves after its high byte
      case ({wr_en, rd_done})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

  // readout FSM, low byte first
  always_ff @(posedge clock or negedge reset_n_i) begin
    if (!reset_n_i) begin
      state_q    <= telemetry_pkg::read_low;
      byte_cnt_q <= '0;
      last_q     <= 1'b0;
    end else begin
      case (state_q)
        telemetry_pkg::read_low: begin
          if (xfer) begin
            state_q <= telemetry_pkg::read_high;
            // only record stored, or the high byte fills the packet
            last_q  <= (level_q == telemetry_pkg::level_t'(1)) ||
                       (byte_cnt_q == usb_pkg::bulk_max_bytes - 2);
          end
        end
        telemetry_pkg::read_high: begin
          if (xfer) begin
            state_q <= last_q ? telemetry_pkg::read_gap : telemetry_pkg::read_low;
          end
        end
        telemetry_pkg::read_gap: state_q <= telemetry_pkg::read_low;  // one idle cycle
        default: state_q <= telemetry_pkg::read_low;
      endcase
      if (xfer) begin
        byte_cnt_q <= beat_o.tlast ? '0 : byte_cnt_q + 1'b1;
      end
    end
  end

  always_comb begin
    case (state_q)
      telemetry_pkg::read_low:  tvalid_o = (level_q != '0);
      telemetry_pkg::read_high: tvalid_o = 1'b1;
      default:                  tvalid_o = 1'b0;
    endcase
  end

  assign beat_o.tdata = (state_q == telemetry_pkg::read_high) ? rd_record[15:8] :
                                                                rd_record[7:0];
  assign beat_o.tkeep = 1'b1;
  assign beat_o.tlast = (state_q == telemetry_pkg::read_high) && last_q;

  assign level_o = level_q;

endmodule

//--- hw/telemetry_pkg.sv
package telemetry_pkg;

  // single-cycle event strobes from the usb core
  typedef struct packed {
    logic sof;
    logic token;
    logic crc_error;
    logic timeout;
    logic bus_reset;
  } usb_events_t;

  localparam int timestamp_width = 11;

  // event mask in the top bits, free-running timestamp below
  typedef struct packed {
    usb_events_t                events;
    logic [timestamp_width-1:0] timestamp;
  } telemetry_record_t;

  localparam int fifo_depth = 64;
  localparam int fifo_addr_width = $clog2(fifo_depth);

  // occupancy needs one bit more than the address, to tell full from empty
  typedef logic [fifo_addr_width:0] level_t;

  localparam level_t present_level = 7'd4;
  localparam level_t ready_level = 7'd16;

  // byte-wise readout of each record
  typedef enum logic [1:0] {
    read_low,
    read_high,
    read_gap
  } readout_state_e;

endpackage

//--- hw/usb_pkg.sv
package usb_pkg;

  // bytes per stream beat are 8 bits wide
  localparam int data_width = 8;

  // one bulk-IN stream beat, byte wide
  typedef struct packed {
    logic [data_width-1:0] tdata;
    logic                  tkeep;
    logic                  tlast;  // final byte of a packet
  } axis_beat_t;

  // endpoint number as announced by the transaction engine
  typedef logic [3:0] endpoint_t;

  // telemetry is read back through this IN endpoint
  localparam endpoint_t telemetry_ep = 4'd2;

  // max bulk packet payload in bytes
  localparam int bulk_max_bytes = 64;

  // width of the per-packet byte counter
  localparam int pkt_count_width = $clog2(bulk_max_bytes);

endpackage

//--- tb/bulk_in_bridge_tb.sv
`timescale 1ns/1ps

module bulk_in_bridge_tb;

  localparam int timeout_cycles = (400 + 600 + 600 + 200) * 5 / 4;

  logic                       clock;
  logic                       areset_n;
  logic                       usb_bus_reset_i;
  telemetry_pkg::usb_events_t usb_events_i;
  usb_pkg::endpoint_t         blk_endpt_i;
  logic                       blk_in_ready_i;
  usb_pkg::axis_beat_t        s_axis_i;
  logic                       s_axis_tvalid_i;
  logic                       s_axis_tready_o;
  logic                       m_axis_tready_i;
  logic                       reset_no;
  logic                       usb_reset_o;
  usb_pkg::axis_beat_t        m_axis_o;
  logic                       m_axis_tvalid_o;
  logic                       blk_in_ready_o;
  logic                       has_telemetry_o;

  integer seed = 32'hffdb0c6e;
  int     errors, tests_ok, tests_bad, cycles, bus_rec_out;
  bit     user_on, events_on, drain, user_xfer;

  // reference model
  int                                        rel_edges;  // edges since areset_n release
  bit                                        m_usb_reset = 1'b1;
  bit                                        m_sel, m_blk_ready, last_flag;
  logic [telemetry_pkg::timestamp_width-1:0] ts;
  logic [15:0]                               recs[$];  // stored telemetry records
  telemetry_pkg::readout_state_e             rstate = telemetry_pkg::read_low;
  int                                        pkt_bytes;
  usb_pkg::axis_beat_t                       pipe[$];  // beats held in the skid buffer
  bit                                        pipe_tag[$];

  bulk_in_bridge u_bulk_in_bridge (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic bit chance(int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  function automatic usb_pkg::endpoint_t other_endpoint();
    usb_pkg::endpoint_t ep;
    ep = $random(seed);
    return (ep == usb_pkg::telemetry_ep) ? 4'd1 : ep;
  endfunction

  task automatic compare_signal(input string name, input logic [15:0] expected,
                                input logic [15:0] actual);
    assert (actual === expected) else begin
      $display("MISMATCH at %0d ns: %s expected %0h, actual %0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_outputs();
    compare_signal("reset_no", rel_edges >= 2, reset_no);
    compare_signal("usb_reset_o", m_usb_reset, usb_reset_o);
    compare_signal("m_axis_tvalid_o", pipe.size() != 0, m_axis_tvalid_o);
    if (pipe.size() != 0) compare_signal("m_axis_o", pipe[0], m_axis_o);
    compare_signal("s_axis_tready_o", !m_sel && pipe.size() < 2, s_axis_tready_o);
    compare_signal("blk_in_ready_o", m_blk_ready, blk_in_ready_o);
    compare_signal("has_telemetry_o", recs.size() >= telemetry_pkg::present_level,
                   has_telemetry_o);
  endtask

  // next-edge state from current inputs
  task automatic advance_model();
    int                            lvl;
    logic [15:0]                   rec;
    bit                            tele_valid, in_xfer, tele_xfer;
    usb_pkg::axis_beat_t           src;
    telemetry_pkg::readout_state_e st;
    lvl = recs.size();
    st = rstate;
    rec = (lvl != 0) ? recs[0] : '0;
    tele_valid = (st == telemetry_pkg::read_high) || (st == telemetry_pkg::read_low && lvl != 0);
    src.tdata = (st == telemetry_pkg::read_high) ? rec[15:8] : rec[7:0];  // low byte first
    src.tkeep = 1'b1;
    src.tlast = (st == telemetry_pkg::read_high) && last_flag;
    if (!m_sel) src = s_axis_i;
    in_xfer = (m_sel ? tele_valid : s_axis_tvalid_i) && pipe.size() < 2;
    user_xfer = in_xfer && !m_sel;
    tele_xfer = in_xfer && m_sel;
    if (pipe.size() != 0 && m_axis_tready_i) begin
      if (pipe_tag.pop_front()) bus_rec_out++;
      void'(pipe.pop_front());
    end
    if (in_xfer) begin
      pipe.push_back(src);
      pipe_tag.push_back(tele_xfer && st == telemetry_pkg::read_high && rec[11]);
    end
    if (m_usb_reset) begin
      pipe.delete();
      pipe_tag.delete();
    end
    if (rel_edges < 2) begin
      ts = '0;
      recs.delete();
      rstate = telemetry_pkg::read_low;
      pkt_bytes = 0;
      last_flag = 1'b0;
    end else begin
      if (tele_xfer && st == telemetry_pkg::read_low) begin
        // final stored record, or the high byte fills the packet
        last_flag = (lvl == 1) || (pkt_bytes + 2 == usb_pkg::bulk_max_bytes);
        rstate = telemetry_pkg::read_high;
      end else if (tele_xfer) begin
        rstate = last_flag ? telemetry_pkg::read_gap : telemetry_pkg::read_low;
        void'(recs.pop_front());
      end else if (st == telemetry_pkg::read_gap) begin
        rstate = telemetry_pkg::read_low;
      end
      if (tele_xfer) pkt_bytes = src.tlast ? 0 : pkt_bytes + 1;
      if (usb_events_i != 5'b0 && lvl != telemetry_pkg::fifo_depth) begin
        recs.push_back({usb_events_i, ts});  // dropped while full
      end
      ts++;
    end
    m_blk_ready = blk_in_ready_i || lvl >= telemetry_pkg::ready_level;
    m_sel = !m_usb_reset && (blk_endpt_i == usb_pkg::telemetry_ep);
    m_usb_reset = (rel_edges < 2) || usb_bus_reset_i;
    if (rel_edges < 3) rel_edges++;
  endtask

  task automatic drive_inputs();
    logic [3:0] mask;
    if (user_xfer || !s_axis_tvalid_i) begin
      s_axis_tvalid_i = user_on && chance(60);
      s_axis_i = $random(seed);
    end
    mask = $random(seed);
    if (mask == 4'b0) mask = 4'b1000;
    usb_events_i = '0;
    if (events_on && chance(20)) usb_events_i = {mask, 1'b0};  // bus_reset bit kept clear
    m_axis_tready_i = drain || chance(70);
    blk_in_ready_i = chance(25);
  endtask

  task automatic run_cycles(int n);
    repeat (n) begin
      @(negedge clock);
      check_outputs();
      advance_model();
      @(posedge clock);
      #2;
      drive_inputs();
    end
  endtask

  task automatic finish_test(string name, int errors_before);
    if (errors == errors_before) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  initial begin
    int mark;
    areset_n = 1'b0;
    usb_bus_reset_i = 1'b0;
    usb_events_i = '0;
    blk_endpt_i = 4'd1;
    blk_in_ready_i = 1'b0;
    s_axis_i = '0;
    s_axis_tvalid_i = 1'b0;
    m_axis_tready_i = 1'b0;
    repeat (8) @(posedge clock);
    #2;
    areset_n = 1'b1;
    mark = errors;
    run_cycles(4);
    finish_test("reset sequence", mark);
    mark = errors;
    blk_endpt_i = other_endpoint();
    user_on = 1'b1;
    events_on = 1'b1;
    run_cycles(400);
    finish_test("user stream", mark);
    mark = errors;
    user_on = 1'b0;
    blk_endpt_i = usb_pkg::telemetry_ep;
    run_cycles(600);
    finish_test("telemetry readout", mark);
    mark = errors;
    user_on = 1'b1;
    repeat (12) begin
      blk_endpt_i = chance(50) ? usb_pkg::telemetry_ep : other_endpoint();
      run_cycles(50);
    end
    finish_test("status flags", mark);
    mark = errors;
    user_on = 1'b0;
    events_on = 1'b0;
    drain = 1'b1;
    blk_endpt_i = usb_pkg::telemetry_ep;
    run_cycles(100);  // room in the FIFO for the bus reset record
    usb_bus_reset_i = 1'b1;
    usb_events_i.bus_reset = 1'b1;
    run_cycles(2);
    usb_bus_reset_i = 1'b0;
    events_on = 1'b1;
    drain = 1'b0;
    run_cycles(98);
    events_on = 1'b0;
    drain = 1'b1;
    while (recs.size() != 0 || pipe.size() != 0) run_cycles(1);
    assert (bus_rec_out != 0) else begin
      $display("the bus reset record never came out of the bulk-IN stream");
      errors++;
    end
    finish_test("bus reset", mark);
    $display("tests ok: %0d, tests with errors: %0d, total errors: %0d",
             tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
